// ==== design/link_pkg.sv ====
package link_pkg;

  // one byte on the host link
  typedef logic [7:0] byte_t;

  // command byte codes
  typedef enum logic [7:0] {
    CMD_NOP   = 8'h00,
    CMD_READ  = 8'h01,
    CMD_WRITE = 8'h02
  } cmd_t;

  typedef enum logic [3:0] {
    CMND,
    ADDR0,
    ADDR1,
    DATA0,
    DATA1,
    WRITE,
    READ,
    REPLY0,
    REPLY1
  } bridge_state_t;

endpackage

// ==== design/bus_pkg.sv ====
package bus_pkg;

  localparam int ADDR_W = 16;
  localparam int DATA_W = 16;

  // word-wide bus, byte pairs on the link
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;

endpackage

// ==== design/wb_if.sv ====
`timescale 1ns/1ns

interface wb_if;

  logic           cyc;
  logic           stb;
  logic           we;
  bus_pkg::addr_t adr;
  bus_pkg::data_t dat_w;  // master to target
  bus_pkg::data_t dat_r;  // target to master
  logic           ack;
  logic           err;

  modport master (
    output cyc, stb, we, adr, dat_w,
    input  dat_r, ack, err
  );

  modport target (
    input  cyc, stb, we, adr, dat_w,
    output dat_r, ack, err
  );

endinterface

// ==== design/as_rx_queue.sv ====
`timescale 1ns/1ns

module as_rx_queue #(
  parameter int QUEUE_DEPTH = 8
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            push_i,
  input  link_pkg::byte_t data_i,
  input  logic            pop_i,
  output logic            valid_o,
  output link_pkg::byte_t data_o,
  output logic            full_o
);

  localparam int PTR_W = $clog2(QUEUE_DEPTH);
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

  link_pkg::byte_t  mem [QUEUE_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;  // wraps, depth is a power of two
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  assign full_o  = (count == CNT_W'(QUEUE_DEPTH));
  assign valid_o = (count != '0);
  assign data_o  = mem[rd_ptr];
  assign do_push = push_i && !full_o;  // drop when full
  assign do_pop  = pop_i && valid_o;

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop) rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= data_i;
  end

endmodule

// ==== design/as_wb_bridge.sv ====
`timescale 1ns/1ns

module as_wb_bridge (
  input  logic            clk,
  input  logic            reset,
  input  logic            rx_valid_i,
  input  link_pkg::byte_t rx_data_i,
  output logic            rx_pop_o,
  input  logic            as_busy_i,
  output logic            as_dstrb_o,
  output link_pkg::byte_t as_data_o,
  wb_if.master            bus
);

  link_pkg::bridge_state_t state;
  logic                    is_write;  // latched from the command byte
  bus_pkg::data_t          rd_buf;

  // one byte consumed per cycle in the receiving states
  always_comb begin
    case (state)
      link_pkg::CMND,
      link_pkg::ADDR0,
      link_pkg::ADDR1,
      link_pkg::DATA0,
      link_pkg::DATA1: rx_pop_o = rx_valid_i;
      default:         rx_pop_o = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= link_pkg::CMND;
      is_write   <= 1'b0;
      as_dstrb_o <= 1'b0;
      bus.cyc    <= 1'b0;
      bus.stb    <= 1'b0;
    end else begin
      as_dstrb_o <= 1'b0;  // single-cycle pulse
      case (state)
        link_pkg::CMND: begin
          if (rx_valid_i) begin
            case (link_pkg::cmd_t'(rx_data_i))
              link_pkg::CMD_WRITE: begin
                is_write <= 1'b1;
                state    <= link_pkg::ADDR0;
              end
              link_pkg::CMD_READ: begin
                is_write <= 1'b0;
                state    <= link_pkg::ADDR0;
              end
              default: state <= link_pkg::CMND;  // nop or unknown code, dropped
            endcase
          end
        end
        link_pkg::ADDR0: begin
          if (rx_valid_i) begin
            bus.adr[7:0] <= rx_data_i;
            state        <= link_pkg::ADDR1;
          end
        end
        link_pkg::ADDR1: begin
          if (rx_valid_i) begin
            bus.adr[15:8] <= rx_data_i;
            if (is_write) begin
              state <= link_pkg::DATA0;
            end else begin
              bus.cyc <= 1'b1;
              bus.stb <= 1'b1;
              bus.we  <= 1'b0;
              state   <= link_pkg::READ;
            end
          end
        end
        link_pkg::DATA0: begin
          if (rx_valid_i) begin
            bus.dat_w[7:0] <= rx_data_i;
            state          <= link_pkg::DATA1;
          end
        end
        link_pkg::DATA1: begin
          if (rx_valid_i) begin
            bus.dat_w[15:8] <= rx_data_i;
            bus.cyc         <= 1'b1;
            bus.stb         <= 1'b1;
            bus.we          <= 1'b1;
            state           <= link_pkg::WRITE;
          end
        end
        link_pkg::WRITE: begin
          if (bus.ack || bus.err) begin
            bus.cyc <= 1'b0;
            bus.stb <= 1'b0;
            state   <= link_pkg::CMND;
          end
        end
        link_pkg::READ: begin
          if (bus.err) begin
            bus.cyc <= 1'b0;  // no reply on err
            bus.stb <= 1'b0;
            state   <= link_pkg::CMND;
          end else if (bus.ack) begin
            bus.cyc <= 1'b0;
            bus.stb <= 1'b0;
            rd_buf  <= bus.dat_r;
            state   <= link_pkg::REPLY0;
          end
        end
        link_pkg::REPLY0: begin
          if (!as_busy_i) begin
            as_data_o  <= rd_buf[7:0];  // low byte first
            as_dstrb_o <= 1'b1;
            state      <= link_pkg::REPLY1;
          end
        end
        link_pkg::REPLY1: begin
          // previous strobe keeps the bytes at least two cycles apart
          if (!as_busy_i && !as_dstrb_o) begin
            as_data_o  <= rd_buf[15:8];
            as_dstrb_o <= 1'b1;
            state      <= link_pkg::CMND;
          end
        end
        default: state <= link_pkg::CMND;
      endcase
    end
  end

endmodule

// ==== design/wb_reg_bank.sv ====
`timescale 1ns/1ns

module wb_reg_bank #(
  parameter int REG_COUNT = 16
) (
  input  logic clk,
  input  logic reset,
  wb_if.target bus
);

  localparam int IDX_W = (REG_COUNT > 1) ? $clog2(REG_COUNT) : 1;

  bus_pkg::data_t   regs [REG_COUNT];
  logic             req;
  logic             in_range;
  logic [IDX_W-1:0] idx;

  // new request only once the previous response has cleared
  assign req      = bus.cyc && bus.stb && !bus.ack && !bus.err;
  assign in_range = (bus.adr < bus_pkg::addr_t'(REG_COUNT));
  assign idx      = bus.adr[IDX_W-1:0];

  always_ff @(posedge clk) begin
    if (reset) begin
      bus.ack <= 1'b0;
      bus.err <= 1'b0;
      for (int i = 0; i < REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else begin
      bus.ack <= req && in_range;
      bus.err <= req && !in_range;  // regs untouched
      if (req && in_range && bus.we) regs[idx] <= bus.dat_w;
    end
  end

  // read word, valid alongside ack
  always_ff @(posedge clk) begin
    if (req && in_range && !bus.we) bus.dat_r <= regs[idx];
  end

endmodule

// ==== design/as_wb_subsystem.sv ====
`timescale 1ns/1ns

module as_wb_subsystem #(
  parameter int QUEUE_DEPTH = 8,
  parameter int REG_COUNT   = 16
) (
  input  logic            clk,
  input  logic            reset,
  input  link_pkg::byte_t as_data_i,
  input  logic            as_dstrb_i,
  output logic            as_full_o,
  input  logic            as_busy_i,
  output link_pkg::byte_t as_data_o,
  output logic            as_dstrb_o
);

  logic            rx_valid;
  link_pkg::byte_t rx_data;
  logic            rx_pop;

  wb_if wb_bus ();

  // host bytes wait here while a transfer runs
  as_rx_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) u_rx_queue (
    .clk     (clk),
    .reset   (reset),
    .push_i  (as_dstrb_i),
    .data_i  (as_data_i),
    .pop_i   (rx_pop),
    .valid_o (rx_valid),
    .data_o  (rx_data),
    .full_o  (as_full_o)
  );

  as_wb_bridge u_bridge (
    .clk        (clk),
    .reset      (reset),
    .rx_valid_i (rx_valid),
    .rx_data_i  (rx_data),
    .rx_pop_o   (rx_pop),
    .as_busy_i  (as_busy_i),
    .as_dstrb_o (as_dstrb_o),
    .as_data_o  (as_data_o),
    .bus        (wb_bus.master)
  );

  wb_reg_bank #(
    .REG_COUNT (REG_COUNT)
  ) u_reg_bank (
    .clk   (clk),
    .reset (reset),
    .bus   (wb_bus.target)
  );

endmodule

// ==== dv/as_wb_subsystem_tb.sv ====
`timescale 1ns/1ns

module as_wb_subsystem_tb;

  localparam int QUEUE_DEPTH    = 8;
  localparam int REG_COUNT      = 16;
  localparam int TAB_LEN        = 24;
  localparam int TIMEOUT_CYCLES = TAB_LEN * 40 + 200;

  logic            clk;
  logic            reset;
  link_pkg::byte_t as_data_i;
  logic            as_dstrb_i;
  logic            as_full_o;
  logic            as_busy_i;
  link_pkg::byte_t as_data_o;
  logic            as_dstrb_o;

  // stimulus table, expected columns filled by the scoreboard
  link_pkg::byte_t tab_cmd   [TAB_LEN];
  bus_pkg::addr_t  tab_addr  [TAB_LEN];
  bus_pkg::data_t  tab_data  [TAB_LEN];
  logic            tab_burst [TAB_LEN];
  logic            tab_reply [TAB_LEN];
  bus_pkg::data_t  tab_exp   [TAB_LEN];
  bus_pkg::data_t  sb_regs   [REG_COUNT];
  bus_pkg::data_t  exp_words [TAB_LEN];

  int              n_entries;
  int              exp_count;
  int              rx_idx;
  int              cycle_cnt;
  int              value_errs;
  int              proto_errs;
  logic            have_low;
  link_pkg::byte_t low_byte;
  logic            busy_prev;
  logic            dstrb_prev;

  as_wb_subsystem #(
    .QUEUE_DEPTH (QUEUE_DEPTH),
    .REG_COUNT   (REG_COUNT)
  ) UUT (
    .clk        (clk),
    .reset      (reset),
    .as_data_i  (as_data_i),
    .as_dstrb_i (as_dstrb_i),
    .as_full_o  (as_full_o),
    .as_busy_i  (as_busy_i),
    .as_data_o  (as_data_o),
    .as_dstrb_o (as_dstrb_o)
  );

  always #10 clk = ~clk;

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("Error at %0t: %s expected %b, got %b", $time, name, exp, act);
      value_errs++;
    end
  endtask

  task automatic check_byte(input string name, input link_pkg::byte_t exp,
                            input link_pkg::byte_t act);
    if (exp !== act) begin
      $display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
      value_errs++;
    end
  endtask

  task automatic check_word(input string name, input bus_pkg::data_t exp,
                            input bus_pkg::data_t act);
    if (exp !== act) begin
      $display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
      value_errs++;
    end
  endtask

  task automatic add_entry(input link_pkg::byte_t cmd, input bus_pkg::addr_t addr,
                           input bus_pkg::data_t data, input logic burst);
    tab_cmd[n_entries]   = cmd;
    tab_addr[n_entries]  = addr;
    tab_data[n_entries]  = data;
    tab_burst[n_entries] = burst;
    n_entries++;
  endtask

  task automatic load_table();
    add_entry(link_pkg::CMD_READ,  16'h0003, 16'h0000, 1'b0);  // untouched after reset
    add_entry(link_pkg::CMD_READ,  16'h000f, 16'h0000, 1'b0);
    add_entry(link_pkg::CMD_WRITE, 16'h0001, 16'ha5c3, 1'b0);
    add_entry(link_pkg::CMD_WRITE, 16'h0007, 16'h1234, 1'b0);
    add_entry(link_pkg::CMD_WRITE, 16'h000f, 16'hbeef, 1'b0);
    add_entry(link_pkg::CMD_READ,  16'h0001, 16'h0000, 1'b0);
    add_entry(link_pkg::CMD_READ,  16'h0007, 16'h0000, 1'b0);
    add_entry(link_pkg::CMD_READ,  16'h000f, 16'h0000, 1'b0);
    add_entry(link_pkg::CMD_WRITE, 16'h0010, 16'hdead, 1'b0);  // out of range
    add_entry(link_pkg::CMD_READ,  16'h0000, 16'h0000, 1'b0);
    add_entry(link_pkg::CMD_READ,  16'h0010, 16'h0000, 1'b0);
    add_entry(link_pkg::CMD_READ,  16'h8001, 16'h0000, 1'b0);
    add_entry(link_pkg::CMD_READ,  16'h0001, 16'h0000, 1'b0);
    add_entry(link_pkg::CMD_NOP,   16'h0000, 16'h0000, 1'b0);
    add_entry(8'h7f,               16'h0000, 16'h0000, 1'b0);  // unknown code
    add_entry(link_pkg::CMD_WRITE, 16'h0002, 16'h0f0f, 1'b0);
    add_entry(8'hff,               16'h0000, 16'h0000, 1'b0);
    add_entry(link_pkg::CMD_READ,  16'h0002, 16'h0000, 1'b0);
    add_entry(link_pkg::CMD_WRITE, 16'h0004, 16'h4444, 1'b1);  // back to back from here
    add_entry(link_pkg::CMD_READ,  16'h0004, 16'h0000, 1'b1);
    add_entry(link_pkg::CMD_WRITE, 16'h0005, 16'h5a5a, 1'b1);
    add_entry(link_pkg::CMD_READ,  16'h0005, 16'h0000, 1'b1);
    add_entry(link_pkg::CMD_READ,  16'h0007, 16'h0000, 1'b1);
    add_entry(link_pkg::CMD_READ,  16'h0001, 16'h0000, 1'b1);
  endtask

  // register model, run over the table in command order
  task automatic run_scoreboard();
    logic in_range;
    for (int r = 0; r < REG_COUNT; r++) begin
      sb_regs[r] = '0;
    end
    exp_count = 0;
    for (int i = 0; i < n_entries; i++) begin
      in_range     = tab_addr[i] < bus_pkg::addr_t'(REG_COUNT);
      tab_reply[i] = 1'b0;
      tab_exp[i]   = '0;
      if (tab_cmd[i] == link_pkg::CMD_WRITE && in_range) begin
        sb_regs[int'(tab_addr[i])] = tab_data[i];
      end else if (tab_cmd[i] == link_pkg::CMD_READ && in_range) begin
        tab_reply[i] = 1'b1;
        tab_exp[i]   = sb_regs[int'(tab_addr[i])];
      end
      if (tab_reply[i]) begin
        exp_words[exp_count] = tab_exp[i];
        exp_count++;
      end
    end
  endtask

  function automatic int next_gap(input int i);
    if (tab_burst[i]) return 0;
    return int'($urandom % 3);
  endfunction

  task automatic send_byte(input link_pkg::byte_t b, input int gap);
    for (int k = 0; k < gap; k++) begin
      @(posedge clk);
      #2;
    end
    while (as_full_o) begin  // host holds off while full
      @(posedge clk);
      #2;
    end
    as_dstrb_i = 1'b1;
    as_data_i  = b;
    @(posedge clk);
    #2;
    as_dstrb_i = 1'b0;
  endtask

  task automatic send_entry(input int i);
    send_byte(tab_cmd[i], next_gap(i));
    if (tab_cmd[i] == link_pkg::CMD_READ || tab_cmd[i] == link_pkg::CMD_WRITE) begin
      send_byte(tab_addr[i][7:0], next_gap(i));
      send_byte(tab_addr[i][15:8], next_gap(i));
    end
    if (tab_cmd[i] == link_pkg::CMD_WRITE) begin
      send_byte(tab_data[i][7:0], next_gap(i));
      send_byte(tab_data[i][15:8], next_gap(i));
    end
  endtask

  always @(posedge clk) begin
    #2;
    if (!reset) as_busy_i = ($urandom % 3) == 0;
  end

  // busy_prev is the value seen by the edge that raised the strobe
  always @(negedge clk) begin
    if (reset) begin
      check_flag("as_dstrb_o", 1'b0, as_dstrb_o);
      check_flag("as_full_o", 1'b0, as_full_o);
    end else if (as_dstrb_o) begin
      if (busy_prev) begin
        $display("reply strobe at %0t was raised while as_busy_i was high", $time);
        proto_errs++;
      end
      if (dstrb_prev) begin
        $display("reply strobes at %0t came in consecutive cycles", $time);
        proto_errs++;
      end
      if (rx_idx >= exp_count) begin
        $display("reply strobe at %0t was not expected by any command", $time);
        proto_errs++;
      end else if (!have_low) begin
        low_byte = as_data_o;
        have_low = 1'b1;
        check_byte("as_data_o low", exp_words[rx_idx][7:0], as_data_o);
      end else begin
        have_low = 1'b0;
        check_byte("as_data_o high", exp_words[rx_idx][15:8], as_data_o);
        check_word("reply word", exp_words[rx_idx], {as_data_o, low_byte});
        rx_idx++;
      end
    end
    busy_prev  = as_busy_i;
    dstrb_prev = as_dstrb_o;
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, %0d of %0d replies seen",
               cycle_cnt, rx_idx, exp_count);
      $display("errors: %0d value, %0d protocol", value_errs, proto_errs);
      $display("=== FAIL ===");
      $finish;
    end
  end

  initial begin
    void'($urandom(13));
    clk        = 1'b0;
    reset      = 1'b1;
    as_data_i  = '0;
    as_dstrb_i = 1'b0;
    as_busy_i  = 1'b0;
    n_entries  = 0;
    rx_idx     = 0;
    cycle_cnt  = 0;
    value_errs = 0;
    proto_errs = 0;
    have_low   = 1'b0;
    low_byte   = '0;
    busy_prev  = 1'b0;
    dstrb_prev = 1'b0;
    load_table();
    run_scoreboard();
    repeat (16) @(posedge clk);
    #2;
    reset = 1'b0;
    for (int i = 0; i < n_entries; i++) begin
      send_entry(i);
    end
    while (rx_idx < exp_count) begin
      @(posedge clk);
    end
    repeat (8) @(posedge clk);  // catch stray strobes
    $display("errors: %0d value, %0d protocol", value_errs, proto_errs);
    if (value_errs == 0 && proto_errs == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== project.f ====
design/link_pkg.sv
design/bus_pkg.sv
design/wb_if.sv
design/as_rx_queue.sv
design/as_wb_bridge.sv
design/wb_reg_bank.sv
design/as_wb_subsystem.sv
dv/as_wb_subsystem_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module as_wb_subsystem_tb \
  -f project.f --Mdir obj_dir -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
  exit 1
fi
exit 0
